/* dv/mhp_assert.sv */
`default_nettype none

module mhp_assert (
  input wire logic i_clk,
  input wire logic i_rst,
  input wire logic i_rreq,
  input wire logic i_wready,
  input wire logic i_wvalid
);
  timeunit 1ns;
  timeprecision 1ps;

  // pop is a single-cycle pulse
  rreq_single : assert property (@(posedge i_clk) disable iff (i_rst)
    i_rreq |=> !i_rreq)
    else $error("o_rreq was high on two consecutive cycles");

  // a byte goes out only after a ready cycle
  wvalid_after_ready : assert property (@(posedge i_clk) disable iff (i_rst)
    i_wvalid |-> $past(i_wready))
    else $error("o_wvalid rose without i_wready high on the cycle before");

  // handshakes stay quiet in reset
  quiet_in_reset : assert property (@(posedge i_clk)
    i_rst |-> (i_rreq !== 1'b1) && (i_wvalid !== 1'b1))
    else $error("handshake output high while reset is asserted");

endmodule

bind mhp_top mhp_assert u_assert (
  .i_clk    (i_clk),
  .i_rst    (i_rst),
  .i_rreq   (o_rreq),
  .i_wready (i_wready),
  .i_wvalid (o_wvalid)
);

`default_nettype wire

/* dv/mhp_checker.sv */
`default_nettype none

module mhp_checker (
  input  wire logic       i_clk,
  input  wire logic       i_rst,
  input  wire logic       i_rreq,
  input  wire logic [7:0] i_rdata,
  input  wire logic       i_wvalid,
  input  wire logic [7:0] i_wdata,
  input  wire logic       i_frame_begin,
  input  wire logic       i_frame_end,
  input  wire logic       i_test_end,
  input  wire logic [3:0] i_test_id,
  input  wire logic [7:0] i_sent_len,
  output int              o_tx_count,
  output int              o_errors,
  output int              o_frames
);
  timeunit 1ns;
  timeprecision 1ps;
  import mhp_pkg::*;

  logic [7:0] rx_bytes [64];
  logic [7:0] tx_bytes [64];
  int         rx_count;
  logic       pop_d;
  int         test_errors;
  int         test_frames;

  ////////////////////
  // reference model
  ////////////////////
  function automatic logic reply_expected(input logic [7:0] rx [64], input int len);
    logic [6:0] kind;
    if (len < HEADER_BYTES) begin
      return 1'b0;
    end
    kind = rx[6][6:0];
    if (rx[6][ACK_BIT]) begin
      return 1'b0;
    end
    return (kind == 7'h01) || (kind == 7'h04);
  endfunction

  // swapped addresses, size, type, body, 16-bit sum, zero padding
  function automatic logic [8*TX_FRAME_BYTES-1:0] expected_frame(input logic [7:0] rx [64]);
    logic [7:0]                  reply [TX_FRAME_BYTES];
    logic [8*TX_FRAME_BYTES-1:0] packed_frame;
    logic [15:0]                 sum;
    logic                        grant;
    int                          n;
    grant = (rx[6][6:0] == 7'h04);
    for (int k = 0; k < TX_FRAME_BYTES; k++) begin
      reply[k] = 8'h00;
    end
    reply[0] = rx[2];
    reply[1] = rx[3];
    reply[2] = rx[0];
    reply[3] = rx[1];
    reply[4] = 8'h00;
    reply[5] = grant ? 8'd2 : 8'd1;
    reply[6] = grant ? 8'h92 : 8'h81;
    if (grant) begin
      reply[7] = 8'h01;
      reply[8] = 8'h20;
      n = 9;
    end else begin
      reply[7] = 8'h00;
      n = 8;
    end
    sum = 16'h0000;
    for (int k = 0; k < n; k++) begin
      sum = sum + {8'h00, reply[k]};
    end
    reply[n]     = sum[15:8];
    reply[n + 1] = sum[7:0];
    for (int k = 0; k < TX_FRAME_BYTES; k++) begin
      packed_frame[k*8 +: 8] = reply[k];
    end
    return packed_frame;
  endfunction

  // snoop both ports, popped data shows up one cycle after the pop
  always @(posedge i_clk) begin
    if (i_rst || i_frame_begin) begin
      rx_count   <= 0;
      o_tx_count <= 0;
      pop_d      <= 1'b0;
    end else begin
      pop_d <= i_rreq;
      if (pop_d && rx_count < 64) begin
        rx_bytes[rx_count] <= i_rdata;
        rx_count           <= rx_count + 1;
      end
      if (i_wvalid && o_tx_count < 64) begin
        tx_bytes[o_tx_count] <= i_wdata;
        o_tx_count           <= o_tx_count + 1;
      end
    end
  end

  task automatic check_frame();
    logic [8*TX_FRAME_BYTES-1:0] want_frame;
    logic                        want_reply;
    int                          n_err;
    n_err      = 0;
    want_reply = reply_expected(rx_bytes, rx_count);
    if (rx_count != int'(i_sent_len)) begin
      $display("test %0d frame %0d: receiver popped %0d bytes but %0d were sent",
               i_test_id, test_frames, rx_count, i_sent_len);
      n_err++;
    end
    if (!want_reply) begin
      if (o_tx_count != 0) begin
        $display("test %0d frame %0d: unexpected frame of %0d bytes for a frame needing no reply",
                 i_test_id, test_frames, o_tx_count);
        n_err++;
      end
    end else if (o_tx_count == 0) begin
      $display("test %0d frame %0d: reply frame is missing", i_test_id, test_frames);
      n_err++;
    end else begin
      want_frame = expected_frame(rx_bytes);
      if (o_tx_count != TX_FRAME_BYTES) begin
        $display("test %0d frame %0d: reply has %0d bytes instead of %0d",
                 i_test_id, test_frames, o_tx_count, TX_FRAME_BYTES);
        n_err++;
      end
      for (int k = 0; k < TX_FRAME_BYTES && k < o_tx_count; k++) begin
        if (tx_bytes[k] != want_frame[k*8 +: 8]) begin
          $display("Mismatch at %0t: test %0d frame %0d byte %0d is %02h, expected %02h",
                   $time, i_test_id, test_frames, k, tx_bytes[k], want_frame[k*8 +: 8]);
          n_err++;
        end
      end
    end
    test_errors += n_err;
    o_errors    += n_err;
    test_frames++;
    o_frames++;
  endtask

  ////////////////////
  // comparison
  ////////////////////
  always @(posedge i_clk) begin
    if (i_rst) begin
      o_errors    = 0;
      o_frames    = 0;
      test_errors = 0;
      test_frames = 0;
    end else begin
      if (i_frame_end) begin
        check_frame();
      end
      if (i_test_end) begin
        if (test_errors == 0) begin
          $display("test %0d: %0d frames ok", i_test_id, test_frames);
        end else begin
          $display("test %0d: %0d frames, %0d errors", i_test_id, test_frames, test_errors);
        end
        test_errors = 0;
        test_frames = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_mhp.sv */
`default_nettype none

module tb_mhp;
  timeunit 1ns;
  timeprecision 1ps;
  import mhp_pkg::*;

  localparam int NUM_FRAMES     = 27;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * 1200;
  localparam int IDLE_LIMIT     = 400;

  logic        clk;
  logic        rst;
  logic        rx_ready = 1'b0;
  logic [7:0]  rx_data = 8'h00;
  logic        rx_req;
  logic        tx_ready = 1'b0;
  logic [7:0]  tx_data;
  logic        tx_valid;

  // test control toward the checker
  logic        frame_begin;
  logic        frame_end;
  logic        test_end;
  logic [3:0]  test_id;
  logic [7:0]  frame_len;
  int          tx_count;
  int          err_count;
  int          frame_count;

  logic [7:0]  frame_bytes [64];
  logic        load_req;
  logic [7:0]  fifo_q [$];
  logic        stall_mode;
  int          stall_left;
  logic [31:0] stall_rng = 32'd71;
  logic [31:0] rng;

  mhp_top UUT (
    .i_clk    (clk),
    .i_rst    (rst),
    .i_rready (rx_ready),
    .i_rdata  (rx_data),
    .o_rreq   (rx_req),
    .i_wready (tx_ready),
    .o_wdata  (tx_data),
    .o_wvalid (tx_valid)
  );

  mhp_checker u_checker (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_rreq        (rx_req),
    .i_rdata       (rx_data),
    .i_wvalid      (tx_valid),
    .i_wdata       (tx_data),
    .i_frame_begin (frame_begin),
    .i_frame_end   (frame_end),
    .i_test_end    (test_end),
    .i_test_id     (test_id),
    .i_sent_len    (frame_len),
    .o_tx_count    (tx_count),
    .o_errors      (err_count),
    .o_frames      (frame_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // receive FIFO model
  ////////////////////
  always @(posedge clk) begin
    if (rst) begin
      rx_ready <= 1'b0;
      fifo_q.delete();
    end else begin
      if (load_req) begin
        for (int k = 0; k < int'(frame_len); k++) begin
          fifo_q.push_back(frame_bytes[k]);
        end
      end
      if (rx_req && fifo_q.size() > 0) begin
        rx_data <= fifo_q.pop_front();
      end
      rx_ready <= (fifo_q.size() > 0);
    end
  end

  // ready toggles between long low and short high stretches
  always @(posedge clk) begin
    if (rst || !stall_mode) begin
      tx_ready   <= !rst;
      stall_left <= 0;
    end else if (stall_left > 0) begin
      stall_left <= stall_left - 1;
    end else begin
      stall_rng = xorshift32(stall_rng);
      tx_ready <= !tx_ready;
      if (tx_ready) begin
        stall_left <= 8 + int'(stall_rng[3:0]);
      end else begin
        stall_left <= 2 + int'(stall_rng[2:0]);
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  // random bytes, then header fields when the frame is long enough
  task automatic fill_frame(input logic [7:0] type_byte, input int len);
    logic [31:0] r;
    logic [15:0] size_field;
    for (int k = 0; k < len; k++) begin
      r = next_rand();
      frame_bytes[k] = r[7:0];
    end
    if (len >= HEADER_BYTES) begin
      size_field     = 16'(len - HEADER_BYTES);
      frame_bytes[4] = size_field[15:8];
      frame_bytes[5] = size_field[7:0];
      frame_bytes[6] = type_byte;
    end
    frame_len <= 8'(len);
  endtask

  // one frame in, then wait for a full reply or a quiet port
  task automatic run_frame();
    int idle;
    @(posedge clk);
    frame_begin <= 1'b1;
    @(posedge clk);
    frame_begin <= 1'b0;
    load_req    <= 1'b1;
    @(posedge clk);
    load_req <= 1'b0;
    idle = 0;
    while (tx_count < TX_FRAME_BYTES && idle < IDLE_LIMIT) begin
      @(posedge clk);
      if (tx_valid || rx_req) begin
        idle = 0;
      end else begin
        idle++;
      end
    end
    repeat (4) @(posedge clk);
    frame_end <= 1'b1;
    @(posedge clk);
    frame_end <= 1'b0;
  endtask

  task automatic random_request();
    logic [31:0] r;
    logic [7:0]  type_byte;
    int          len;
    r         = next_rand();
    type_byte = r[0] ? TYPE_ADDR_REQ : TYPE_PING_REQ;
    r         = next_rand();
    len       = 7 + int'(r % 32'd34);
    fill_frame(type_byte, len);
    run_frame();
  endtask

  task automatic begin_test(input logic [3:0] id);
    @(posedge clk);
    test_id <= id;
  endtask

  task automatic close_test();
    @(posedge clk);
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
  endtask

  initial begin
    rst         <= 1'b1;
    frame_begin <= 1'b0;
    frame_end   <= 1'b0;
    test_end    <= 1'b0;
    test_id     <= 4'd0;
    load_req    <= 1'b0;
    stall_mode  <= 1'b0;
    rng       = 32'd71;
    frame_len = 8'd0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);

    // ping with random addresses and payload
    begin_test(4'd1);
    fill_frame(TYPE_PING_REQ, 16);
    run_frame();
    close_test();

    begin_test(4'd2);
    fill_frame(TYPE_ADDR_REQ, 10);
    run_frame();
    close_test();

    // acknowledgement, then a request right behind it
    begin_test(4'd3);
    fill_frame(8'h11, 12);
    run_frame();
    fill_frame(TYPE_PING_REQ, 9);
    run_frame();
    close_test();

    // short frame over a ping reply left in the buffer, then an unknown type
    begin_test(4'd4);
    fill_frame(8'h00, 5);
    run_frame();
    fill_frame(8'h07, 12);
    run_frame();
    close_test();

    begin_test(4'd5);
    @(posedge clk);
    stall_mode <= 1'b1;
    fill_frame(TYPE_ADDR_REQ, 24);
    run_frame();
    @(posedge clk);
    stall_mode <= 1'b0;
    close_test();

    begin_test(4'd6);
    repeat (20) random_request();
    close_test();

    repeat (10) @(posedge clk);
    $display("6 tests, %0d frames checked, %0d errors", frame_count, err_count);
    if (err_count == 0 && frame_count == NUM_FRAMES) begin
      $display("Done: no errors");
    end else begin
      if (frame_count != NUM_FRAMES) begin
        $display("only %0d of %0d frames were checked", frame_count, NUM_FRAMES);
      end
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/frame_buffer.sv */
`default_nettype none

module frame_buffer (
  input  wire logic              i_clk,
  input  wire logic              i_rst,
  input  wire mhp_pkg::buf_req_t i_rx_req,
  input  wire mhp_pkg::buf_req_t i_bld_req,
  input  wire mhp_pkg::buf_req_t i_sum_req,
  input  wire mhp_pkg::buf_req_t i_hdr_req,
  input  wire mhp_pkg::buf_req_t i_tx_req,
  output logic [7:0]             o_rdata
);

  logic [7:0] mem [256];
  logic       sel_en;
  logic       sel_we;
  logic [7:0] sel_addr;
  logic [7:0] sel_wdata;
  logic [7:0] rd_byte;

  // fixed priority: rx, builder, checksum, parser, tx
  always_comb begin
    if (i_rx_req.en) begin
      {sel_en, sel_we, sel_addr, sel_wdata} = i_rx_req;
    end else if (i_bld_req.en) begin
      {sel_en, sel_we, sel_addr, sel_wdata} = i_bld_req;
    end else if (i_sum_req.en) begin
      {sel_en, sel_we, sel_addr, sel_wdata} = i_sum_req;
    end else if (i_hdr_req.en) begin
      {sel_en, sel_we, sel_addr, sel_wdata} = i_hdr_req;
    end else begin
      {sel_en, sel_we, sel_addr, sel_wdata} = i_tx_req;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rd_byte <= '0;
    end else if (sel_en) begin
      if (sel_we) begin
        mem[sel_addr] <= sel_wdata;
      end
      rd_byte <= mem[sel_addr];
    end
  end

  assign o_rdata = rd_byte;

endmodule

`default_nettype wire

/* hdl/frame_checksum.sv */
`default_nettype none

module frame_checksum (
  input  wire logic                         i_clk,
  input  wire logic                         i_rst,
  input  wire logic                         i_start,
  input  wire logic [mhp_pkg::BUF_ADDR_W-1:0] i_len,
  input  wire logic [7:0]                   i_rdata,
  output mhp_pkg::buf_req_t                 o_req,
  output logic                              o_done
);
  import mhp_pkg::*;

  typedef enum logic [2:0] {C_IDLE, C_ADDR, C_LOAD, C_WR_HI, C_WR_LO} state_t;

  state_t                state;
  logic [BUF_ADDR_W-1:0] idx;
  logic [15:0]           sum;

  always_comb begin
    o_req = '0;
    case (state)
      C_ADDR: begin
        o_req.en   = 1'b1;
        o_req.addr = idx;
      end
      // sum goes right behind the reply, high byte first
      C_WR_HI: begin
        o_req.en    = 1'b1;
        o_req.we    = 1'b1;
        o_req.addr  = i_len;
        o_req.wdata = sum[15:8];
      end
      C_WR_LO: begin
        o_req.en    = 1'b1;
        o_req.we    = 1'b1;
        o_req.addr  = i_len + 1'b1;
        o_req.wdata = sum[7:0];
      end
      default: o_req = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= C_IDLE;
      idx    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        C_IDLE: begin
          if (i_start) begin
            idx   <= '0;
            state <= C_ADDR;
          end
        end
        C_ADDR: state <= C_LOAD;
        C_LOAD: begin
          if (idx == i_len - 1'b1) begin
            state <= C_WR_HI;
          end else begin
            idx   <= idx + 1'b1;
            state <= C_ADDR;
          end
        end
        C_WR_HI: state <= C_WR_LO;
        C_WR_LO: begin
          o_done <= 1'b1;
          state  <= C_IDLE;
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  // carry out of bit 15 is dropped
  always_ff @(posedge i_clk) begin
    if (state == C_IDLE && i_start) begin
      sum <= '0;
    end else if (state == C_LOAD) begin
      sum <= sum + {8'h00, i_rdata};
    end
  end

endmodule

`default_nettype wire

/* hdl/frame_receiver.sv */
`default_nettype none

module frame_receiver (
  input  wire logic                         i_clk,
  input  wire logic                         i_rst,
  input  wire logic                         i_start,
  input  wire logic                         i_rready,
  input  wire logic [7:0]                   i_rdata,
  output logic                              o_rreq,
  output mhp_pkg::buf_req_t                 o_req,
  output logic [mhp_pkg::BUF_ADDR_W-1:0]    o_len,
  output logic                              o_done
);
  import mhp_pkg::*;

  typedef enum logic [1:0] {RX_IDLE, RX_LISTEN, RX_CAPTURE} state_t;

  state_t     state;
  // cycles since the last pop
  logic [5:0] gap_cnt;

  assign o_rreq = (state == RX_LISTEN) && i_rready;

  // popped byte is valid in the capture cycle, written at the byte count
  always_comb begin
    o_req       = '0;
    o_req.en    = (state == RX_CAPTURE);
    o_req.we    = (state == RX_CAPTURE);
    o_req.addr  = o_len;
    o_req.wdata = i_rdata;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= RX_IDLE;
      gap_cnt <= '0;
      o_len   <= '0;
      o_done  <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (i_start) begin
            o_len   <= '0;
            gap_cnt <= '0;
            state   <= RX_LISTEN;
          end
        end
        RX_LISTEN: begin
          if (i_rready) begin
            gap_cnt <= 6'd1;
            state   <= RX_CAPTURE;
          end else if (gap_cnt == 6'(IDLE_GAP_CYCLES - 1)) begin
            // idle gap reached, frame is complete
            o_done <= 1'b1;
            state  <= RX_IDLE;
          end else begin
            gap_cnt <= gap_cnt + 6'd1;
          end
        end
        RX_CAPTURE: begin
          o_len   <= o_len + 1'b1;
          gap_cnt <= gap_cnt + 6'd1;
          state   <= RX_LISTEN;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/frame_transmitter.sv */
`default_nettype none

module frame_transmitter (
  input  wire logic                         i_clk,
  input  wire logic                         i_rst,
  input  wire logic                         i_start,
  input  wire logic [mhp_pkg::BUF_ADDR_W-1:0] i_len,
  input  wire logic [7:0]                   i_rdata,
  input  wire logic                         i_wready,
  output mhp_pkg::buf_req_t                 o_req,
  output logic [7:0]                        o_wdata,
  output logic                              o_wvalid,
  output logic                              o_done
);
  import mhp_pkg::*;

  typedef enum logic [2:0] {T_IDLE, T_ADDR, T_LOAD, T_SEND, T_GAP} state_t;

  state_t                state;
  logic [BUF_ADDR_W-1:0] idx;

  always_comb begin
    o_req      = '0;
    o_req.en   = (state == T_ADDR);
    o_req.addr = idx;
  end

  ////////////////////
  // byte sequencer
  ////////////////////
  // four cycles per byte at least, longer while the port is busy
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= T_IDLE;
      idx      <= '0;
      o_wvalid <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      o_wvalid <= 1'b0;
      o_done   <= 1'b0;
      case (state)
        T_IDLE: begin
          if (i_start) begin
            idx   <= '0;
            state <= T_ADDR;
          end
        end
        T_ADDR: state <= T_LOAD;
        T_LOAD: state <= T_SEND;
        T_SEND: begin
          // hold here until the port can take the byte
          if (i_wready) begin
            o_wvalid <= 1'b1;
            state    <= T_GAP;
          end
        end
        T_GAP: begin
          if (idx == BUF_ADDR_W'(TX_FRAME_BYTES - 1)) begin
            o_done <= 1'b1;
            state  <= T_IDLE;
          end else begin
            idx   <= idx + 1'b1;
            state <= T_ADDR;
          end
        end
        default: state <= T_IDLE;
      endcase
    end
  end

  // zero padding past the reply
  always_ff @(posedge i_clk) begin
    if (state == T_LOAD) begin
      o_wdata <= (idx < i_len) ? i_rdata : 8'h00;
    end
  end

endmodule

`default_nettype wire

/* hdl/header_parser.sv */
`default_nettype none

module header_parser (
  input  wire logic             i_clk,
  input  wire logic             i_rst,
  input  wire logic             i_start,
  input  wire logic [7:0]       i_rdata,
  output mhp_pkg::buf_req_t     o_req,
  output mhp_pkg::mhp_header_t  o_header,
  output logic                  o_done
);
  import mhp_pkg::*;

  typedef enum logic [1:0] {P_IDLE, P_ADDR, P_LOAD} state_t;

  state_t     state;
  logic [2:0] idx;

  // the start cycle doubles as the first address cycle
  always_comb begin
    o_req      = '0;
    o_req.en   = (state == P_ADDR) || ((state == P_IDLE) && i_start);
    o_req.addr = BUF_ADDR_W'(idx);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= P_IDLE;
      idx    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        P_IDLE: begin
          if (i_start) begin
            state <= P_LOAD;
          end
        end
        P_ADDR: state <= P_LOAD;
        P_LOAD: begin
          if (idx == 3'(HEADER_BYTES - 1)) begin
            idx    <= '0;
            o_done <= 1'b1;
            state  <= P_IDLE;
          end else begin
            idx   <= idx + 3'd1;
            state <= P_ADDR;
          end
        end
        default: state <= P_IDLE;
      endcase
    end
  end

  // seven loads shift the whole header in, first byte ends up on top
  always_ff @(posedge i_clk) begin
    if (state == P_LOAD) begin
      o_header <= {o_header[47:0], i_rdata};
    end
  end

endmodule

`default_nettype wire

/* hdl/mhp_pkg.sv */
`default_nettype none

package mhp_pkg;

  ////////////////////
  // frame format
  ////////////////////
  localparam int BUF_ADDR_W      = 8;
  localparam int HEADER_BYTES    = 7;
  localparam int TX_FRAME_BYTES  = 50;
  localparam int IDLE_GAP_CYCLES = 63;

  // request types that get a reply
  localparam logic [7:0] TYPE_PING_REQ = 8'h01;
  localparam logic [7:0] TYPE_ADDR_REQ = 8'h04;

  // types written into the replies
  localparam logic [7:0] TYPE_PING_RSP   = 8'h81;
  localparam logic [7:0] TYPE_ADDR_GRANT = 8'h92;

  ////////////////////
  // reply bodies
  ////////////////////
  localparam logic [7:0]  PING_BODY      = 8'h00;
  localparam logic [7:0]  PING_BODY_LEN  = 8'd1;
  localparam logic [15:0] GRANT_BODY     = 16'h0120;
  localparam logic [7:0]  GRANT_BODY_LEN = 8'd2;

  // type bit that marks an acknowledgement
  localparam int ACK_BIT = 4;

  // one buffer request per unit
  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [BUF_ADDR_W-1:0] addr;
    logic [7:0]            wdata;
  } buf_req_t;

  typedef struct packed {
    logic       dir;
    logic [6:0] kind;
  } mhp_type_fields_t;

  // type byte, raw or split into direction and kind
  typedef union packed {
    logic [7:0]       raw;
    mhp_type_fields_t f;
  } mhp_type_u;

  // fields in wire order, big-endian
  typedef struct packed {
    logic [15:0] src;
    logic [15:0] dst;
    logic [15:0] size;
    mhp_type_u   htype;
  } mhp_header_t;

endpackage

`default_nettype wire

/* hdl/mhp_top.sv */
`default_nettype none

module mhp_top (
  input  wire logic       i_clk,
  input  wire logic       i_rst,
  input  wire logic       i_rready,
  input  wire logic [7:0] i_rdata,
  output logic            o_rreq,
  input  wire logic       i_wready,
  output logic [7:0]      o_wdata,
  output logic            o_wvalid
);
  import mhp_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE, S_RX, S_PARSE, S_DECIDE, S_BUILD, S_SUM, S_TX
  } state_t;

  state_t                state;
  buf_req_t              rx_req;
  buf_req_t              bld_req;
  buf_req_t              sum_req;
  buf_req_t              hdr_req;
  buf_req_t              tx_req;
  logic [7:0]            buf_rdata;
  logic [BUF_ADDR_W-1:0] rx_len;
  logic [BUF_ADDR_W-1:0] reply_len;
  logic [BUF_ADDR_W-1:0] tx_len;
  mhp_header_t           header;
  logic [6:0]            kind;
  logic                  reply_needed;
  logic                  rx_start, hdr_start, bld_start, sum_start, tx_start;
  logic                  rx_done, hdr_done, bld_done, sum_done, tx_done;

  ////////////////////
  // reply decision
  ////////////////////
  assign kind         = header.htype.f.kind;
  assign reply_needed = (rx_len >= BUF_ADDR_W'(HEADER_BYTES)) && !kind[ACK_BIT] &&
                        ((kind == TYPE_PING_REQ[6:0]) || (kind == TYPE_ADDR_REQ[6:0]));
  // checksum adds two bytes
  assign tx_len       = reply_len + 8'd2;

  // start pulses are registered, one unit runs at a time
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= S_IDLE;
      rx_start  <= 1'b0;
      hdr_start <= 1'b0;
      bld_start <= 1'b0;
      sum_start <= 1'b0;
      tx_start  <= 1'b0;
    end else begin
      rx_start  <= 1'b0;
      hdr_start <= 1'b0;
      bld_start <= 1'b0;
      sum_start <= 1'b0;
      tx_start  <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_rready) begin
            rx_start <= 1'b1;
            state    <= S_RX;
          end
        end
        S_RX: begin
          if (rx_done) begin
            hdr_start <= 1'b1;
            state     <= S_PARSE;
          end
        end
        S_PARSE: begin
          if (hdr_done) begin
            state <= S_DECIDE;
          end
        end
        S_DECIDE: begin
          if (reply_needed) begin
            bld_start <= 1'b1;
            state     <= S_BUILD;
          end else begin
            state <= S_IDLE;
          end
        end
        S_BUILD: begin
          if (bld_done) begin
            sum_start <= 1'b1;
            state     <= S_SUM;
          end
        end
        S_SUM: begin
          if (sum_done) begin
            tx_start <= 1'b1;
            state    <= S_TX;
          end
        end
        S_TX: begin
          if (tx_done) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  frame_buffer u_buf (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_rx_req  (rx_req),
    .i_bld_req (bld_req),
    .i_sum_req (sum_req),
    .i_hdr_req (hdr_req),
    .i_tx_req  (tx_req),
    .o_rdata   (buf_rdata)
  );

  frame_receiver u_rx (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (rx_start),
    .i_rready (i_rready),
    .i_rdata  (i_rdata),
    .o_rreq   (o_rreq),
    .o_req    (rx_req),
    .o_len    (rx_len),
    .o_done   (rx_done)
  );

  header_parser u_hdr (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (hdr_start),
    .i_rdata  (buf_rdata),
    .o_req    (hdr_req),
    .o_header (header),
    .o_done   (hdr_done)
  );

  reply_builder u_bld (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (bld_start),
    .i_header    (header),
    .o_req       (bld_req),
    .o_reply_len (reply_len),
    .o_done      (bld_done)
  );

  frame_checksum u_sum (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (sum_start),
    .i_len   (reply_len),
    .i_rdata (buf_rdata),
    .o_req   (sum_req),
    .o_done  (sum_done)
  );

  frame_transmitter u_tx (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (tx_start),
    .i_len    (tx_len),
    .i_rdata  (buf_rdata),
    .i_wready (i_wready),
    .o_req    (tx_req),
    .o_wdata  (o_wdata),
    .o_wvalid (o_wvalid),
    .o_done   (tx_done)
  );

endmodule

`default_nettype wire

/* hdl/reply_builder.sv */
`default_nettype none

module reply_builder (
  input  wire logic                         i_clk,
  input  wire logic                         i_rst,
  input  wire logic                         i_start,
  input  wire mhp_pkg::mhp_header_t         i_header,
  output mhp_pkg::buf_req_t                 o_req,
  output logic [mhp_pkg::BUF_ADDR_W-1:0]    o_reply_len,
  output logic                              o_done
);
  import mhp_pkg::*;

  logic       busy;
  logic       grant;
  logic       start_grant;
  logic [3:0] idx;
  logic [7:0] body_len;
  mhp_type_u  rsp_type;

  assign start_grant = (i_header.htype.f.kind == TYPE_ADDR_REQ[6:0]);

  ////////////////////
  // reply template
  ////////////////////
  always_comb begin
    rsp_type.raw = grant ? TYPE_ADDR_GRANT : TYPE_PING_RSP;
    body_len     = grant ? GRANT_BODY_LEN : PING_BODY_LEN;
    o_req        = '0;
    o_req.en     = busy;
    o_req.we     = busy;
    o_req.addr   = BUF_ADDR_W'(idx);
    case (idx)
      // addresses swapped
      4'd0:    o_req.wdata = i_header.dst[15:8];
      4'd1:    o_req.wdata = i_header.dst[7:0];
      4'd2:    o_req.wdata = i_header.src[15:8];
      4'd3:    o_req.wdata = i_header.src[7:0];
      // size field holds the body length
      4'd4:    o_req.wdata = 8'h00;
      4'd5:    o_req.wdata = body_len;
      4'd6:    o_req.wdata = rsp_type.raw;
      4'd7:    o_req.wdata = grant ? GRANT_BODY[15:8] : PING_BODY;
      4'd8:    o_req.wdata = GRANT_BODY[7:0];
      default: o_req.wdata = 8'h00;
    endcase
  end

  // one byte per cycle until the reply length is written
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy        <= 1'b0;
      grant       <= 1'b0;
      idx         <= '0;
      o_reply_len <= '0;
      o_done      <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (!busy) begin
        if (i_start) begin
          busy        <= 1'b1;
          idx         <= '0;
          grant       <= start_grant;
          o_reply_len <= BUF_ADDR_W'(HEADER_BYTES) +
                         (start_grant ? GRANT_BODY_LEN : PING_BODY_LEN);
        end
      end else if ({4'd0, idx} == o_reply_len - 1'b1) begin
        busy   <= 1'b0;
        o_done <= 1'b1;
      end else begin
        idx <= idx + 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_mhp -o sim_mhp; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_mhp)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

/* tb.f */
hdl/mhp_pkg.sv
hdl/frame_buffer.sv
hdl/frame_receiver.sv
hdl/header_parser.sv
hdl/reply_builder.sv
hdl/frame_checksum.sv
hdl/frame_transmitter.sv
hdl/mhp_top.sv
dv/mhp_assert.sv
dv/mhp_checker.sv
dv/tb_mhp.sv
